// ==== flist.f ====
+incdir+include
src/mat_mul_pkg.sv
src/row_mem.sv
src/operand_sequencer.sv
src/processing_element.sv
src/pe_array.sv
src/result_collector.sv
src/mat_mul_top.sv
tb/mat_mul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the matrix multiplier testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module mat_mul_tb -o mat_mul_sim

# the log decides pass or fail
./obj_dir/mat_mul_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^Result: PASSED$" sim.log

// ==== src/mat_mul_pkg.sv ====
package mat_mul_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////

  // element width in bits
  localparam int dwidth = 16;
  // row memory address width and depth
  localparam int awidth = 7;
  localparam int mem_depth = 128;
  // array is mat_size x mat_size
  localparam int mat_size = 4;
  // address register plus output register in row_mem
  localparam int rd_latency = 2;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef logic [dwidth-1:0] elem_t;
  // full precision accumulator, wraps mod 2^32
  typedef logic [2*dwidth-1:0] acc_t;
  // lane 0 in the low bits
  typedef elem_t [mat_size-1:0] row_t;
  // indexed by output row
  typedef row_t [mat_size-1:0] mat_t;
  typedef logic [awidth-1:0] addr_t;

  //////////////////////////////////////////////////////////////////////
  // run schedule
  //////////////////////////////////////////////////////////////////////

  // last product lands in pe (n-1,n-1) after read latency,
  // n-1 feed steps and 2*(n-1) hops through the array
  localparam int drain_count = rd_latency + 3 * (mat_size - 1) + 1;
  // one c row written per cycle after drain
  localparam int done_count = drain_count + mat_size;

endpackage

// ==== src/mat_mul_top.sv ====
`timescale 1ns/1ns

module mat_mul_top (
  input  logic               clk,
  input  logic               reset_0,
  input  logic               wr_a,
  input  logic               wr_b,
  input  mat_mul_pkg::addr_t wr_addr,
  input  mat_mul_pkg::row_t  wr_data,
  input  mat_mul_pkg::addr_t rd_addr,
  output mat_mul_pkg::row_t  rd_data,
  input  logic               start,
  output logic               done
);
  import mat_mul_pkg::*;

  // operand memories
  addr_t a_mem_addr;
  addr_t b_mem_addr;
  row_t  a_row;
  row_t  b_row;
  // sequencer side
  addr_t seq_a_addr;
  addr_t seq_b_addr;
  row_t  a_lanes;
  row_t  b_lanes;
  logic  clear;
  logic  drain;
  // array and write-back
  mat_t  results;
  logic  c_we;
  addr_t c_addr;
  row_t  c_wdata;
  addr_t c_mem_addr;

  //////////////////////////////////////////////////////////////////////
  // host port arbitration
  //////////////////////////////////////////////////////////////////////

  // host owns a and b while idle
  assign a_mem_addr = start ? seq_a_addr : wr_addr;
  assign b_mem_addr = start ? seq_b_addr : wr_addr;
  // collector owns c only while writing
  assign c_mem_addr = c_we ? c_addr : rd_addr;

  row_mem a_mem (
    .clk     (clk),
    .reset_0 (reset_0),
    .addr    (a_mem_addr),
    .wdata   (wr_data),
    .we      (wr_a && !start),
    .rdata   (a_row)
  );

  row_mem b_mem (
    .clk     (clk),
    .reset_0 (reset_0),
    .addr    (b_mem_addr),
    .wdata   (wr_data),
    .we      (wr_b && !start),
    .rdata   (b_row)
  );

  row_mem c_mem (
    .clk     (clk),
    .reset_0 (reset_0),
    .addr    (c_mem_addr),
    .wdata   (c_wdata),
    .we      (c_we),
    .rdata   (rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // engine
  //////////////////////////////////////////////////////////////////////

  operand_sequencer operand_sequencer_inst (
    .clk     (clk),
    .reset_0 (reset_0),
    .start   (start),
    .a_row   (a_row),
    .b_row   (b_row),
    .a_addr  (seq_a_addr),
    .b_addr  (seq_b_addr),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .clear   (clear),
    .drain   (drain)
  );

  pe_array pe_array_inst (
    .clk     (clk),
    .reset_0 (reset_0),
    .clear   (clear),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .results (results)
  );

  result_collector result_collector_inst (
    .clk     (clk),
    .reset_0 (reset_0),
    .start   (start),
    .drain   (drain),
    .results (results),
    .c_we    (c_we),
    .c_addr  (c_addr),
    .c_wdata (c_wdata),
    .done    (done)
  );

endmodule

// ==== src/operand_sequencer.sv ====
`timescale 1ns/1ns

module operand_sequencer (
  input  logic               clk,
  input  logic               reset_0,
  input  logic               start,
  input  mat_mul_pkg::row_t  a_row,
  input  mat_mul_pkg::row_t  b_row,
  output mat_mul_pkg::addr_t a_addr,
  output mat_mul_pkg::addr_t b_addr,
  output mat_mul_pkg::row_t  a_lanes,
  output mat_mul_pkg::row_t  b_lanes,
  output logic               clear,
  output logic               drain
);
  import mat_mul_pkg::*;

  // run counter, freezes at done_count
  logic [$clog2(done_count+1)-1:0] cnt;
  addr_t rd_addr;
  // memory outputs with stale rows masked off
  row_t  a_feed;
  row_t  b_feed;

  //////////////////////////////////////////////////////////////////////
  // run counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_0 || !start) begin
      cnt <= '0;
    end else if (cnt != done_count) begin
      cnt <= cnt + 1'b1;
    end
  end

  // steps 0..n-1 read rows 0..n-1, then park on the zero row
  assign rd_addr = (cnt < mat_size) ? addr_t'(cnt) : addr_t'(mem_depth - 1);
  assign a_addr  = rd_addr;
  assign b_addr  = rd_addr;

  // first two cycles the memories still show host traffic
  assign a_feed = (cnt >= rd_latency) ? a_row : '0;
  assign b_feed = (cnt >= rd_latency) ? b_row : '0;

  //////////////////////////////////////////////////////////////////////
  // skew, lane k delayed by k cycles
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < mat_size; k++) begin : g_lane
    if (k == 0) begin : g_direct
      // lane 0 goes straight in
      assign a_lanes[k] = a_feed[k];
      assign b_lanes[k] = b_feed[k];
    end else begin : g_delay
      elem_t [k-1:0] a_pipe;
      elem_t [k-1:0] b_pipe;

      always_ff @(posedge clk) begin
        if (reset_0 || !start) begin
          a_pipe <= '0;
          b_pipe <= '0;
        end else begin
          a_pipe[0] <= a_feed[k];
          b_pipe[0] <= b_feed[k];
          for (int s = 1; s < k; s++) begin
            a_pipe[s] <= a_pipe[s-1];
            b_pipe[s] <= b_pipe[s-1];
          end
        end
      end

      // oldest stage drives the lane
      assign a_lanes[k] = a_pipe[k-1];
      assign b_lanes[k] = b_pipe[k-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control outputs
  //////////////////////////////////////////////////////////////////////

  // accumulators held at zero while idle
  assign clear = !start;
  // last product has settled in the far corner
  assign drain = (cnt == drain_count);

  a_drain_not_in_clear: assert property (@(posedge clk) disable iff (reset_0)
    !(drain && clear))
    else $error("drain raised while array is cleared");

endmodule

// ==== src/pe_array.sv ====
`timescale 1ns/1ns

module pe_array (
  input  logic              clk,
  input  logic              reset_0,
  input  logic              clear,
  input  mat_mul_pkg::row_t a_lanes,
  input  mat_mul_pkg::row_t b_lanes,
  output mat_mul_pkg::mat_t results
);
  import mat_mul_pkg::*;

  // a_h[r][c] feeds pe (r,c) from the left, last column leaves the array
  elem_t a_h [mat_size][mat_size+1];
  // b_v[r][c] feeds pe (r,c) from the top, last row leaves the array
  elem_t b_v [mat_size+1][mat_size];

  //////////////////////////////////////////////////////////////////////
  // edge injection
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < mat_size; i++) begin : g_edge
    // a lane i enters row i
    assign a_h[i][0] = a_lanes[i];
    // b lane i enters column i
    assign b_v[0][i] = b_lanes[i];
  end

  //////////////////////////////////////////////////////////////////////
  // grid
  //////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < mat_size; r++) begin : g_row
    for (genvar c = 0; c < mat_size; c++) begin : g_col
      processing_element pe_inst (
        .clk     (clk),
        .reset_0 (reset_0),
        .clear   (clear),
        .in_a    (a_h[r][c]),
        .in_b    (b_v[r][c]),
        .out_a   (a_h[r][c+1]),
        .out_b   (b_v[r+1][c]),
        .result  (results[r][c])
      );
    end
  end

endmodule

// ==== src/processing_element.sv ====
`timescale 1ns/1ns

module processing_element (
  input  logic                clk,
  input  logic                reset_0,
  input  logic                clear,
  input  mat_mul_pkg::elem_t  in_a,
  input  mat_mul_pkg::elem_t  in_b,
  output mat_mul_pkg::elem_t  out_a,
  output mat_mul_pkg::elem_t  out_b,
  output mat_mul_pkg::elem_t  result
);
  import mat_mul_pkg::*;

  acc_t acc;

  // forward operands one hop, accumulate the product
  always_ff @(posedge clk) begin
    if (reset_0 || clear) begin
      out_a <= '0;
      out_b <= '0;
      acc   <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
      // unsigned, full 32 bit product, sum wraps
      acc   <= acc + acc_t'(in_a) * acc_t'(in_b);
    end
  end

  // saturate to all ones on any upper bit
  assign result = (|acc[2*dwidth-1:dwidth]) ? '1 : acc[dwidth-1:0];

endmodule

// ==== src/result_collector.sv ====
`timescale 1ns/1ns

module result_collector (
  input  logic               clk,
  input  logic               reset_0,
  input  logic               start,
  input  logic               drain,
  input  mat_mul_pkg::mat_t  results,
  output logic               c_we,
  output mat_mul_pkg::addr_t c_addr,
  output mat_mul_pkg::row_t  c_wdata,
  output logic               done
);
  import mat_mul_pkg::*;

  // snapshot of the array results
  mat_t held;
  // row being written
  logic [$clog2(mat_size)-1:0] row_idx;

  //////////////////////////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (drain) begin
      held <= results;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write-back sequence
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_0 || !start) begin
      c_we    <= 1'b0;
      row_idx <= '0;
      done    <= 1'b0;
    end else if (drain) begin
      // row 0 goes out on the next cycle
      c_we    <= 1'b1;
      row_idx <= '0;
    end else if (c_we) begin
      row_idx <= row_idx + 1'b1;
      // last row leaving this cycle
      if (row_idx == mat_size - 1) begin
        c_we <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // row i lands at address i
  assign c_addr  = addr_t'(row_idx);
  assign c_wdata = held[row_idx];

  // host may read c once done is up, so no write may overlap it
  a_no_write_after_done: assert property (@(posedge clk) disable iff (reset_0)
    !(c_we && done))
    else $error("c write while done is high");

endmodule

// ==== src/row_mem.sv ====
`timescale 1ns/1ns

module row_mem (
  input  logic               clk,
  input  logic               reset_0,
  input  mat_mul_pkg::addr_t addr,
  input  mat_mul_pkg::row_t  wdata,
  input  logic               we,
  output mat_mul_pkg::row_t  rdata
);
  import mat_mul_pkg::*;

  // storage, no reset on the array itself
  row_t  mem [mem_depth];
  addr_t addr_q;

  // all rows start at zero, top row stays zero
  initial begin
    for (int i = 0; i < mem_depth; i++) begin
      mem[i] = '0;
    end
  end

  // write goes straight in at the edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // read path: address reg, then output reg
  always_ff @(posedge clk) begin
    if (reset_0) begin
      addr_q <= '0;
      rdata  <= '0;
    end else begin
      addr_q <= addr;
      rdata  <= mem[addr_q];
    end
  end

  // sequencer parks on the top row to read zeros
  a_top_row_kept_zero: assert property (@(posedge clk) disable iff (reset_0)
    we |-> addr != addr_t'(mem_depth - 1))
    else $error("row_mem write to reserved row");

endmodule

// ==== include/mat_mul_tb_checks.svh ====
// reference product built from the element rules
// 32 bit sum wraps, any upper bit set saturates to all ones
function automatic mat_t ref_product(input mat_t a, input mat_t b);
  mat_t c;
  acc_t sum;
  for (int i = 0; i < mat_size; i++) begin
    for (int j = 0; j < mat_size; j++) begin
      sum = '0;
      for (int t = 0; t < mat_size; t++) begin
        sum = sum + acc_t'(a[i][t]) * acc_t'(b[t][j]);
      end
      // upper half nonzero means the element overflowed
      c[i][j] = (sum[2*dwidth-1:dwidth] != '0) ? '1 : sum[dwidth-1:0];
    end
  end
  return c;
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

// one c row against its expected value
task automatic check_row(input string name, input row_t expected, input row_t actual);
  if (actual !== expected) begin
    stop_with_failure($sformatf("[ERROR] %s: expected %h, actual %h",
                                name, expected, actual));
  end
endtask

// done flag against its expected level
task automatic check_done(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    stop_with_failure($sformatf("[ERROR] %s: expected done %b, actual done %b",
                                name, expected, actual));
  end
endtask

// ==== tb/mat_mul_tb.sv ====
`timescale 1ns/1ns

module mat_mul_tb;
  import mat_mul_pkg::*;

  localparam int num_cases = 6;
  // far above the fixed run length
  localparam int done_timeout = 200;

  logic  clk;
  logic  reset_0;
  logic  wr_a;
  logic  wr_b;
  addr_t wr_addr;
  row_t  wr_data;
  addr_t rd_addr;
  row_t  rd_data;
  logic  start;
  logic  done;

  int    seed;
  // case table, expected c filled in when built
  string case_name [num_cases];
  mat_t  case_a [num_cases];
  mat_t  case_b [num_cases];
  mat_t  case_c [num_cases];

  mat_mul_top mat_mul_top_inst (
    .clk     (clk),
    .reset_0 (reset_0),
    .wr_a    (wr_a),
    .wr_b    (wr_b),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .start   (start),
    .done    (done)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  `include "mat_mul_tb_checks.svh"

  //////////////////////////////////////////////////////////////////////
  // host side helpers
  //////////////////////////////////////////////////////////////////////

  // a memory row t holds column t of a
  function automatic row_t column_of(input mat_t m, input int t);
    row_t col;
    for (int k = 0; k < mat_size; k++) begin
      col[k] = m[k][t];
    end
    return col;
  endfunction

  task automatic write_row(input logic to_a, input addr_t addr, input row_t data);
    @(posedge clk);
    #2;
    wr_a    = to_a;
    wr_b    = !to_a;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk);
    #2;
    wr_a = 1'b0;
    wr_b = 1'b0;
  endtask

  // address sampled, then output registered
  task automatic read_c_row(input addr_t addr, output row_t row);
    @(posedge clk);
    #2;
    rd_addr = addr;
    repeat (2) @(posedge clk);
    #1;
    row = rd_data;
  endtask

  task automatic wait_for_done(input string name);
    int cycles;
    cycles = 0;
    while (done !== 1'b1) begin
      if (cycles == done_timeout) begin
        stop_with_failure($sformatf("timeout: done never rose in case %s", name));
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // case table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    mat_t pat;
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        pat[i][j]       = elem_t'(4 * i + j + 1);
        case_a[0][i][j] = (i == j) ? elem_t'(1) : elem_t'(0);
        case_a[1][i][j] = '0;
        case_b[1][i][j] = '0;
        case_a[2][i][j] = elem_t'(i + 2 * j + 3);
        // rows hit the 0x10000 edge, sit just under it, stay small, overflow
        case_a[3][i][j] = (i == 0) ? 16'h4000 :
                          (i == 1) ? ((j == 0) ? 16'h3fff : 16'h4000) :
                          (i == 2) ? 16'h00ff : 16'hffff;
        case_b[3][i][j] = elem_t'(j % 3);
        case_a[4][i][j] = elem_t'($random(seed));
        case_b[4][i][j] = elem_t'($random(seed));
        // byte operands keep every sum exact
        case_a[5][i][j] = elem_t'($random(seed)) & 16'h00ff;
        case_b[5][i][j] = elem_t'($random(seed)) & 16'h00ff;
      end
    end
    case_b[0] = pat;
    case_b[2] = pat;
    case_name[0] = "identity_times_b";
    // zeros right after a nonzero run
    case_name[1] = "zeros";
    case_name[2] = "small_pattern";
    case_name[3] = "saturation";
    case_name[4] = "random_full";
    case_name[5] = "random_byte";
    for (int n = 0; n < num_cases; n++) begin
      case_c[n] = ref_product(case_a[n], case_b[n]);
    end
  endtask

  task automatic run_case(input int n);
    row_t got;
    for (int t = 0; t < mat_size; t++) begin
      write_row(1'b1, addr_t'(t), column_of(case_a[n], t));
      write_row(1'b0, addr_t'(t), case_b[n][t]);
    end
    @(posedge clk);
    #2;
    start = 1'b1;
    wait_for_done(case_name[n]);
    // read back while start is held
    for (int i = 0; i < mat_size; i++) begin
      read_c_row(addr_t'(i), got);
      check_row($sformatf("%s row %0d", case_name[n], i), case_c[n][i], got);
    end
    check_done({case_name[n], " held"}, 1'b1, done);
    @(posedge clk);
    #2;
    start = 1'b0;
    @(posedge clk);
    #1;
    check_done({case_name[n], " release"}, 1'b0, done);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    row_t  got;
    addr_t probe;
    clk         = 1'b0;
    reset_0     = 1'b1;
    start       = 1'b0;
    wr_a        = 1'b0;
    wr_b        = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    rd_addr     = '0;
    seed        = 66;
    build_table();
    repeat (16) @(posedge clk);
    #2;
    reset_0 = 1'b0;
    // idle state, c memory empty
    check_done("after_reset", 1'b0, done);
    for (int i = 0; i < mat_size; i++) begin
      read_c_row(addr_t'(i), got);
      check_row($sformatf("after_reset row %0d", i), '0, got);
    end
    for (int r = 0; r < 3; r++) begin
      probe = addr_t'($random(seed));
      read_c_row(probe, got);
      check_row($sformatf("after_reset addr %0d", probe), '0, got);
    end
    for (int n = 0; n < num_cases; n++) begin
      run_case(n);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule
